// File: Makefile
VERILATOR  ?= verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = potionTb
FILELIST   = filelist.f
BUILD_DIR  = obj_dir
SOURCES    = $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: dv/potionAssertions.sv
`timescale 1ns/1ps

module potionAssertions import potionPkg::*; (
    input logic                    single_pulse_clk,
    input logic                    reset,
    input logic                    menu,
    input logic [numCursorPos-1:0] confirmed,
    input logic                    ended,
    input logic                    won,
    input logic [11:0]             timeLeft
);

    ////////////////////////////////////////////////////////////
    // Controller invariants
    ////////////////////////////////////////////////////////////
    confirmedOneHot: assert property (@(posedge single_pulse_clk) disable iff (reset)
        $onehot0(confirmed))
        else $error("confirmed selects more than one tube");

    wonEndedExclusive: assert property (@(posedge single_pulse_clk) disable iff (reset)
        !(won && ended))
        else $error("won and ended are high together");

    // Timer only reloads through menu or reset
    timerNeverRises: assert property (@(posedge single_pulse_clk) disable iff (reset)
        (!$past(reset) && !$past(menu)) |-> timeLeft <= $past(timeLeft))
        else $error("timeLeft went up without menu or reset");

endmodule

// File: dv/potionTb.sv
`timescale 1ns/1ps

module potionTb import potionPkg::*; ();

    typedef struct packed {
        buttonsT   press;
        tubeIndexT cursor;    // Expected cursor after the press
        tubeIndexT confirm;   // Expected confirmed tube, giveUpPos for none
    } stepT;

    localparam buttonsT pressLeft   = 5'b10000;
    localparam buttonsT pressRight  = 5'b01000;
    localparam buttonsT pressUp     = 5'b00100;
    localparam buttonsT pressDown   = 5'b00010;
    localparam buttonsT pressCentre = 5'b00001;
    localparam int      readyLimit  = 80;       // Scramble bound in cycles

    logic                    single_pulse_clk = 1'b0;
    logic                    reset;
    logic                    start;
    logic                    menu;
    logic                    shuffleBit;
    buttonsT                 buttons;
    boardT                   board;
    logic [numCursorPos-1:0] selected;
    logic [numCursorPos-1:0] confirmed;
    logic                    ready;
    logic                    ended;
    logic                    won;
    logic [6:0]              timePercent;
    logic [9:0]              score;

    logic [31:0] lcgState = 32'd68;
    int          playCycles;
    boardT       modelBoard;
    stepT        steps[$];

    always #5 single_pulse_clk = ~single_pulse_clk;

    potionTop UUT (
        .single_pulse_clk (single_pulse_clk),
        .reset            (reset),
        .start            (start),
        .menu             (menu),
        .shuffleBit       (shuffleBit),
        .buttons          (buttons),
        .board            (board),
        .selected         (selected),
        .confirmed        (confirmed),
        .ready            (ready),
        .ended            (ended),
        .won              (won),
        .timePercent      (timePercent),
        .score            (score)
    );

    bind gameControl potionAssertions controlChecks (
        .single_pulse_clk (single_pulse_clk),
        .reset            (reset),
        .menu             (menu),
        .confirmed        (confirmed),
        .ended            (ended),
        .won              (won),
        .timeLeft         (timeLeft)
    );

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] lcgNext(logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic boardT startPattern();
        boardT b;
        b = '0;                                 // Last tube stays empty
        for (int t = 0; t < numTubes - 1; t++) begin
            b[t].height = 3'd4;
            for (int s = 0; s < tubeDepth; s++) begin
                b[t].slots[s] = colourT'(t + 1);
            end
        end
        return b;
    endfunction

    // Top ball moves while the colours agree, at most four times
    function automatic boardT referencePour(boardT b, tubeIndexT src, tubeIndexT dst);
        boardT r;
        int    hs;
        int    hd;
        r = b;
        for (int n = 0; n < tubeDepth; n++) begin
            hs = int'(r[src].height);
            hd = int'(r[dst].height);
            if (hs > 0 && hd < tubeDepth
                && (hd == 0 || r[dst].slots[hd-1] == r[src].slots[hs-1])) begin
                r[dst].slots[hd]   = r[src].slots[hs-1];
                r[src].slots[hs-1] = EMPTY;
                r[src].height      = heightT'(hs - 1);
                r[dst].height      = heightT'(hd + 1);
            end
        end
        return r;
    endfunction

    function automatic int countComplete(boardT b);
        int n;
        n = 0;
        for (int t = 0; t < numTubes; t++) begin
            if (b[t].slots[0] == b[t].slots[1] && b[t].slots[1] == b[t].slots[2]
                && b[t].slots[2] == b[t].slots[3]) n++;
        end
        return n;
    endfunction

    function automatic int expectedScore(int completed, int percent, logic isEnded);
        int base;
        int penalty;
        base = completed * pointsPerTube;
        if (isEnded) base = (completed > 5) ? base - endPenalty : 0;
        penalty = (100 - percent) * timePenaltyPerPercent;
        return (penalty < base) ? base - penalty : 0;
    endfunction

    function automatic logic [numCursorPos-1:0] expectedConfirmed(tubeIndexT c);
        return (c == giveUpPos) ? '0 : (8'h01 << c);
    endfunction

    function automatic stepT makeStep(buttonsT b, tubeIndexT c, tubeIndexT f);
        stepT s;
        s.press   = b;
        s.cursor  = c;
        s.confirm = f;
        return s;
    endfunction

    ////////////////////////////////////////////////////////////
    // Checks and stimulus helpers
    ////////////////////////////////////////////////////////////
    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkEqual(input logic [127:0] actual, input logic [127:0] expected,
                              input string what);
        if (actual !== expected)
            failRun($sformatf("mismatch at %0t ns: %s (got 'h%0h, expected 'h%0h)",
                              $time, what, actual, expected));
    endtask

    task automatic tick();
        @(posedge single_pulse_clk);
        #1;
        playCycles++;
    endtask

    task automatic pressButtons(input buttonsT b);
        buttons = b;
        tick();
        buttons = '0;
    endtask

    task automatic checkResetValues();
        checkEqual(ready, 1'b0, "ready after reset");
        checkEqual(ended, 1'b0, "ended after reset");
        checkEqual(won, 1'b0, "won after reset");
        checkEqual(selected, 8'h01, "cursor after reset");
        checkEqual(confirmed, 8'h00, "confirmed after reset");
        checkEqual(timePercent, 7'd100, "timePercent after reset");
        checkEqual(128'(board), 128'(startPattern()), "board after reset");
    endtask

    // Four balls per colour, balls packed at the bottom of each tube
    task automatic checkScrambled(input boardT b);
        int counts [8];
        foreach (counts[c]) counts[c] = 0;
        for (int t = 0; t < numTubes; t++) begin
            checkEqual(b[t].height <= 3'd4, 1'b1, $sformatf("height of tube %0d", t));
            for (int s = 0; s < tubeDepth; s++) begin
                if (s < int'(b[t].height)) begin
                    checkEqual(b[t].slots[s] != EMPTY, 1'b1,
                               $sformatf("ball missing in tube %0d slot %0d", t, s));
                    counts[int'(b[t].slots[s])]++;
                end else begin
                    checkEqual(b[t].slots[s], EMPTY,
                               $sformatf("ball above fill height in tube %0d slot %0d", t, s));
                end
            end
        end
        for (int c = 1; c < 7; c++) checkEqual(counts[c], 4, $sformatf("balls of colour %0d", c));
    endtask

    task automatic startGame();
        int waited;
        start = 1'b1;
        tick();
        start = 1'b0;
        waited = 1;
        while (!ready) begin
            if (waited >= readyLimit) failRun("ready did not rise within 80 cycles of start");
            else begin
                tick();
                waited++;
            end
        end
        playCycles = 0;                         // timeLeft is still full here
        modelBoard = board;
        checkScrambled(board);
        checkEqual(ended, 1'b0, "ended at start of play");
    endtask

    task automatic checkPlay();
        int percent;
        percent = (int'(timeLimit) - playCycles) * 100 / int'(timeLimit);
        checkEqual(128'(board), 128'(modelBoard), "board against reference model");
        checkEqual(timePercent, percent, "timePercent during play");
        checkEqual(score, expectedScore(countComplete(modelBoard), int'(timePercent), 1'b0),
                   "score during play");
        checkEqual(ended, 1'b0, "ended during play");
    endtask

    ////////////////////////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////////////////////////
    initial begin
        int limitCycles;
        #1;
        limitCycles = 2 * (4 + readyLimit + steps.size() + int'(timeLimit));
        repeat (limitCycles) @(posedge single_pulse_clk);
        failRun("watchdog expired before the test sequence finished");
    end

    // Random scramble bit, one new value per cycle
    always @(posedge single_pulse_clk) begin
        #1;
        lcgState   = lcgNext(lcgState);
        shuffleBit = lcgState[16];
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        tubeIndexT  prevCursor;
        tubeIndexT  prevConfirm;
        boardT      frozenBoard;
        logic [6:0] frozenPercent;
        int         waited;

        reset      = 1'b1;
        start      = 1'b0;
        menu       = 1'b0;
        shuffleBit = 1'b0;
        buttons    = '0;
        playCycles = 0;

        // Cursor edges and blocked moves
        steps.push_back(makeStep(pressLeft, 3'd0, giveUpPos));
        steps.push_back(makeStep(pressUp, 3'd0, giveUpPos));
        steps.push_back(makeStep(pressDown, 3'd4, giveUpPos));
        steps.push_back(makeStep(pressDown, 3'd4, giveUpPos));
        steps.push_back(makeStep(pressLeft, 3'd4, giveUpPos));
        steps.push_back(makeStep(pressRight, 3'd5, giveUpPos));
        steps.push_back(makeStep(pressRight, 3'd6, giveUpPos));
        steps.push_back(makeStep(pressRight, 3'd7, giveUpPos));
        steps.push_back(makeStep(pressRight, 3'd7, giveUpPos));
        steps.push_back(makeStep(pressUp, 3'd3, giveUpPos));
        steps.push_back(makeStep(pressRight, 3'd3, giveUpPos));
        steps.push_back(makeStep(pressLeft | pressRight, 3'd2, giveUpPos));
        steps.push_back(makeStep(pressUp | pressDown, 3'd6, giveUpPos));
        steps.push_back(makeStep(pressLeft | pressUp, 3'd2, giveUpPos));
        // Confirm, cancel and pour
        steps.push_back(makeStep(pressCentre, 3'd2, 3'd2));
        steps.push_back(makeStep(pressCentre, 3'd2, giveUpPos));
        steps.push_back(makeStep(pressCentre, 3'd2, 3'd2));
        steps.push_back(makeStep(pressLeft, 3'd1, 3'd2));
        steps.push_back(makeStep(pressCentre, 3'd1, giveUpPos));
        steps.push_back(makeStep(pressDown, 3'd5, giveUpPos));
        steps.push_back(makeStep(pressCentre, 3'd5, 3'd5));
        steps.push_back(makeStep(pressRight, 3'd6, 3'd5));
        steps.push_back(makeStep(pressCentre, 3'd6, giveUpPos));
        steps.push_back(makeStep(pressCentre, 3'd6, 3'd6));
        steps.push_back(makeStep(pressRight, 3'd7, 3'd6));
        steps.push_back(makeStep(pressCentre, 3'd7, giveUpPos));   // Drops without pouring
        steps.push_back(makeStep(pressUp, 3'd3, giveUpPos));
        steps.push_back(makeStep(pressCentre, 3'd3, 3'd3));
        steps.push_back(makeStep(pressLeft, 3'd2, 3'd3));
        steps.push_back(makeStep(pressCentre, 3'd2, giveUpPos));
        steps.push_back(makeStep(pressCentre, 3'd2, 3'd2));
        steps.push_back(makeStep(pressRight, 3'd3, 3'd2));
        steps.push_back(makeStep(pressCentre, 3'd3, giveUpPos));

        repeat (4) @(posedge single_pulse_clk);
        #1;
        reset = 1'b0;
        checkResetValues();

        // First game, driven from the table
        startGame();
        prevCursor  = 3'd0;
        prevConfirm = giveUpPos;
        for (int i = 0; i < steps.size(); i++) begin
            if (steps[i].press.centre && prevConfirm != giveUpPos
                && prevCursor != prevConfirm && prevCursor != giveUpPos)
                modelBoard = referencePour(modelBoard, prevConfirm, prevCursor);
            pressButtons(steps[i].press);
            checkEqual(selected, 8'h01 << steps[i].cursor, $sformatf("cursor at step %0d", i));
            checkEqual(confirmed, expectedConfirmed(steps[i].confirm),
                       $sformatf("confirmed at step %0d", i));
            checkPlay();
            prevCursor  = steps[i].cursor;
            prevConfirm = steps[i].confirm;
        end

        // Give up from the last slot
        pressButtons(pressDown);
        checkEqual(selected, 8'h80, "cursor on the give-up slot");
        pressButtons(pressCentre);
        checkEqual(ended, 1'b1, "ended after give-up");
        checkEqual(won, 1'b0, "won after give-up");
        checkEqual(score, expectedScore(countComplete(modelBoard), int'(timePercent), 1'b1),
                   "score after give-up");
        frozenBoard   = board;
        frozenPercent = timePercent;
        pressButtons(pressUp);
        repeat (4) tick();
        checkEqual(selected, 8'h80, "cursor frozen after the game");
        checkEqual(timePercent, frozenPercent, "timer frozen after the game");
        checkEqual(128'(board), 128'(frozenBoard), "board frozen after the game");

        menu = 1'b1;
        tick();
        menu = 1'b0;
        checkResetValues();

        // Second game runs out of time
        startGame();
        waited = 0;
        while (!ended) begin
            if (waited > int'(timeLimit)) failRun("timer did not end the second game");
            else begin
                tick();
                waited++;
            end
        end
        checkEqual(waited, int'(timeLimit), "cycles of play before the timer ran out");
        checkEqual(timePercent, 7'd0, "timePercent after time out");
        checkEqual(score, expectedScore(countComplete(modelBoard), 0, 1'b1),
                   "score after time out");

        menu = 1'b1;
        tick();
        menu = 1'b0;
        checkResetValues();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: filelist.f
hdl/potionPkg.sv
hdl/gameControl.sv
hdl/tubeBoard.sv
hdl/scrambleEngine.sv
hdl/pourUnit.sv
hdl/scoreUnit.sv
hdl/potionTop.sv
dv/potionAssertions.sv
dv/potionTb.sv

// File: hdl/gameControl.sv
`timescale 1ns/1ps

module gameControl import potionPkg::*; (
    input  logic                    single_pulse_clk,
    input  logic                    reset,
    input  logic                    start,
    input  logic                    menu,
    input  buttonsT                 buttons,
    input  logic                    scrambleDone,
    input  logic                    allComplete,
    output boardCmdT                boardCmd,
    output tubeIndexT               pourSrc,
    output tubeIndexT               pourDst,
    output logic                    scrambleInit,
    output logic [11:0]             timeLeft,
    output logic [numCursorPos-1:0] selected,
    output logic [numCursorPos-1:0] confirmed,
    output logic                    ready,
    output logic                    ended,
    output logic                    won
);

    gameStateT state;
    tubeIndexT cursor;
    tubeIndexT confirmIdx;    // giveUpPos when nothing is confirmed
    tubeIndexT nextCursor;
    tubeIndexT nextConfirm;
    logic      giveUp;
    logic      pourReq;

    // Arrows, later ones in the list override earlier ones
    always_comb begin
        nextCursor = cursor;
        if (buttons.left && cursor != 3'd0 && cursor != 3'd4) nextCursor = cursor - 3'd1;
        if (buttons.right && cursor != 3'd3 && cursor != 3'd7) nextCursor = cursor + 3'd1;
        if (buttons.up && cursor >= 3'd4) nextCursor = cursor - 3'd4;
        if (buttons.down && cursor < 3'd4) nextCursor = cursor + 3'd4;
    end

    ////////////////////////////////////////////////////////////
    // Centre button
    ////////////////////////////////////////////////////////////
    always_comb begin
        nextConfirm = confirmIdx;
        giveUp      = 1'b0;
        if (buttons.centre) begin
            if (cursor == confirmIdx) begin
                if (confirmIdx == giveUpPos) giveUp = 1'b1;  // Give-up slot, nothing held
                else nextConfirm = giveUpPos;                // Cancel
            end else if (confirmIdx != giveUpPos) begin
                nextConfirm = giveUpPos;                     // Pour or drop the selection
            end else begin
                nextConfirm = cursor;
            end
        end
    end

    assign pourReq = buttons.centre && confirmIdx != giveUpPos
                     && cursor != confirmIdx && cursor != giveUpPos;

    always_comb begin
        boardCmd = HOLD;
        if (menu) begin
            boardCmd = LOAD_START;
        end else begin
            case (state)
                IDLE:     if (start) boardCmd = LOAD_START;
                SCRAMBLE: if (!scrambleDone) boardCmd = SCRAMBLE_STEP;
                PLAY:     if (pourReq) boardCmd = POUR_STEP;
                default:  boardCmd = HOLD;   // Board frozen after the game
            endcase
        end
    end

    assign scrambleInit = state == IDLE && start && !menu;
    assign pourSrc      = confirmIdx;
    assign pourDst      = cursor;

    ////////////////////////////////////////////////////////////
    // State, timer, cursor
    ////////////////////////////////////////////////////////////
    always_ff @(posedge single_pulse_clk) begin
        if (reset || menu) begin
            state      <= IDLE;
            timeLeft   <= timeLimit;
            cursor     <= 3'd0;
            confirmIdx <= giveUpPos;
        end else begin
            case (state)
                IDLE:     if (start) state <= SCRAMBLE;
                SCRAMBLE: if (scrambleDone) state <= PLAY;
                PLAY: begin
                    timeLeft   <= timeLeft - 12'd1;
                    cursor     <= nextCursor;
                    confirmIdx <= nextConfirm;
                    if (allComplete) state <= WON;
                    else if (giveUp || timeLeft == 12'd1) state <= ENDED;  // Timer runs out
                end
                default: state <= state;   // WON and ENDED wait for menu
            endcase
        end
    end

    always_comb begin
        selected         = '0;
        selected[cursor] = 1'b1;
        confirmed        = '0;
        if (confirmIdx != giveUpPos) confirmed[confirmIdx] = 1'b1;
    end

    assign ready = state inside {PLAY, WON, ENDED};
    assign ended = state == ENDED;
    assign won   = state == WON;

endmodule

// File: hdl/potionPkg.sv
package potionPkg;

    ////////////////////////////////////////////////////////////
    // Board geometry and game constants
    ////////////////////////////////////////////////////////////
    localparam int numTubes     = 7;
    localparam int tubeDepth    = 4;
    localparam int numCursorPos = 8;

    typedef logic [2:0] tubeIndexT;   // Tube number or cursor position

    localparam tubeIndexT   giveUpPos             = 3'd7; // Also means nothing confirmed
    localparam logic [11:0] timeLimit             = 12'd2000; // Countdown in cycles
    localparam int          maxScramblePours      = 70;
    localparam int          pointsPerTube         = 100;
    localparam int          endPenalty            = 500;
    localparam int          timePenaltyPerPercent = 5;

    ////////////////////////////////////////////////////////////
    // Board types
    ////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        EMPTY,
        COLOUR1,
        COLOUR2,
        COLOUR3,
        COLOUR4,
        COLOUR5,
        COLOUR6
    } colourT;                        // Code 7 left unused

    typedef logic [2:0] heightT;      // Balls in a tube, 0 to 4

    typedef struct packed {
        colourT [tubeDepth-1:0] slots; // Slot 0 is the bottom
        heightT                 height;
    } tubeT;

    typedef tubeT [numTubes-1:0] boardT;

    typedef struct packed {
        logic left;
        logic right;
        logic up;
        logic down;
        logic centre;
    } buttonsT;

    typedef enum logic [2:0] {IDLE, SCRAMBLE, PLAY, WON, ENDED} gameStateT;

    typedef enum logic [1:0] {HOLD, LOAD_START, SCRAMBLE_STEP, POUR_STEP} boardCmdT;

    // Move the top ball of src onto dst
    // Caller makes sure src holds a ball and dst has room
    function automatic boardT moveBall(boardT b, tubeIndexT src, tubeIndexT dst);
        boardT      r;
        logic [1:0] srcTop;
        logic [1:0] dstFree;
        r       = b;
        srcTop  = 2'(b[src].height - 3'd1);
        dstFree = b[dst].height[1:0];
        r[dst].slots[dstFree] = b[src].slots[srcTop];
        r[src].slots[srcTop]  = EMPTY;
        r[src].height         = b[src].height - 3'd1;
        r[dst].height         = b[dst].height + 3'd1;
        return r;
    endfunction

endpackage

// File: hdl/potionTop.sv
`timescale 1ns/1ps

module potionTop import potionPkg::*; (
    input  logic                    single_pulse_clk,
    input  logic                    reset,
    input  logic                    start,        // Pulse from the outer game
    input  logic                    menu,         // Pulse, back to menu
    input  logic                    shuffleBit,   // Random bit used while scrambling
    input  buttonsT                 buttons,
    output boardT                   board,
    output logic [numCursorPos-1:0] selected,
    output logic [numCursorPos-1:0] confirmed,
    output logic                    ready,
    output logic                    ended,
    output logic                    won,
    output logic [6:0]              timePercent,
    output logic [9:0]              score
);

    boardCmdT    boardCmd;
    tubeIndexT   pourSrc;
    tubeIndexT   pourDst;
    logic        scrambleInit;
    logic        scrambleDone;
    boardT       scrambleNext;
    boardT       pouredBoard;
    logic [11:0] timeLeft;
    logic        allComplete;

    ////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////
    gameControl control (
        .single_pulse_clk (single_pulse_clk),
        .reset            (reset),
        .start            (start),
        .menu             (menu),
        .buttons          (buttons),
        .scrambleDone     (scrambleDone),
        .allComplete      (allComplete),
        .boardCmd         (boardCmd),
        .pourSrc          (pourSrc),
        .pourDst          (pourDst),
        .scrambleInit     (scrambleInit),
        .timeLeft         (timeLeft),
        .selected         (selected),
        .confirmed        (confirmed),
        .ready            (ready),
        .ended            (ended),
        .won              (won)
    );

    ////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////
    tubeBoard tubes (
        .single_pulse_clk (single_pulse_clk),
        .reset            (reset),
        .boardCmd         (boardCmd),
        .scrambleNext     (scrambleNext),
        .pouredBoard      (pouredBoard),
        .board            (board)
    );

    scrambleEngine scrambler (
        .single_pulse_clk (single_pulse_clk),
        .reset            (reset),
        .scrambleInit     (scrambleInit),
        .shuffleBit       (shuffleBit),
        .board            (board),
        .scrambleNext     (scrambleNext),
        .scrambleDone     (scrambleDone)
    );

    pourUnit pour (
        .board       (board),
        .pourSrc     (pourSrc),
        .pourDst     (pourDst),
        .pouredBoard (pouredBoard)
    );

    scoreUnit scorer (
        .board       (board),
        .timeLeft    (timeLeft),
        .ended       (ended),
        .timePercent (timePercent),
        .score       (score),
        .allComplete (allComplete)
    );

endmodule

// File: hdl/pourUnit.sv
`timescale 1ns/1ps

module pourUnit import potionPkg::*; (
    input  boardT     board,
    input  tubeIndexT pourSrc,
    input  tubeIndexT pourDst,
    output boardT     pouredBoard
);

    boardT work;
    logic  validPair;

    // Matching-colour rule for a single ball
    function automatic logic canMove(boardT b, tubeIndexT src, tubeIndexT dst);
        heightT hs;
        heightT hd;
        logic   ok;
        hs = b[src].height;
        hd = b[dst].height;
        ok = 1'b0;
        if (hs != 3'd0 && hd < heightT'(tubeDepth)) begin
            if (hd == 3'd0) ok = 1'b1;   // Empty tube takes anything
            else ok = b[dst].slots[2'(hd - 3'd1)] == b[src].slots[2'(hs - 3'd1)];
        end
        return ok;
    endfunction

    assign validPair = pourSrc < tubeIndexT'(numTubes)
                       && pourDst < tubeIndexT'(numTubes)
                       && pourSrc != pourDst;

    ////////////////////////////////////////////////////////////
    // Up to four single-ball moves, chained
    ////////////////////////////////////////////////////////////
    always_comb begin
        work = board;
        if (validPair) begin
            for (int n = 0; n < tubeDepth; n++) begin
                if (canMove(work, pourSrc, pourDst)) begin
                    work = moveBall(work, pourSrc, pourDst);
                end
            end
        end
    end

    assign pouredBoard = work;

endmodule

// File: hdl/scoreUnit.sv
`timescale 1ns/1ps

module scoreUnit import potionPkg::*; (
    input  boardT       board,
    input  logic [11:0] timeLeft,
    input  logic        ended,
    output logic [6:0]  timePercent,
    output logic [9:0]  score,
    output logic        allComplete
);

    logic [2:0]  completed;
    logic [18:0] scaledTime;
    logic [9:0]  baseScore;
    logic [9:0]  penalty;

    // Empty tubes count as complete too
    always_comb begin
        completed = '0;
        for (int i = 0; i < numTubes; i++) begin
            if (board[i].slots[0] == board[i].slots[1]
                && board[i].slots[1] == board[i].slots[2]
                && board[i].slots[2] == board[i].slots[3])
                completed = completed + 3'd1;
        end
    end

    assign allComplete = completed == 3'(numTubes);

    assign scaledTime  = 19'(timeLeft) * 19'd100;
    assign timePercent = 7'(scaledTime / 19'(timeLimit));   // Floor

    ////////////////////////////////////////////////////////////
    // Score
    ////////////////////////////////////////////////////////////
    always_comb begin
        baseScore = 10'(completed) * 10'(pointsPerTube);
        if (ended) begin
            if (completed > 3'd5) baseScore = baseScore - 10'(endPenalty);
            else baseScore = '0;
        end
        penalty = 10'(7'd100 - timePercent) * 10'(timePenaltyPerPercent);   // Per percent elapsed
        score   = (penalty < baseScore) ? baseScore - penalty : 10'd0;
    end

endmodule

// File: hdl/scrambleEngine.sv
`timescale 1ns/1ps

module scrambleEngine import potionPkg::*; (
    input  logic  single_pulse_clk,
    input  logic  reset,
    input  logic  scrambleInit,
    input  logic  shuffleBit,
    input  boardT board,
    output boardT scrambleNext,
    output logic  scrambleDone
);

    typedef struct packed {
        logic      found;
        tubeIndexT idx;
    } searchT;

    tubeIndexT  srcTube;
    logic [6:0] pourCount;
    logic       stopped;

    tubeIndexT  dst;
    logic       dstFound;
    boardT      moved;
    tubeIndexT  newSrc;
    logic       halt;
    searchT     refill;
    searchT     skip;

    // Single ball on top, or top two balls alike
    function automatic logic isUsable(tubeT t);
        logic usable;
        usable = 1'b0;
        if (t.height == 3'd1) usable = 1'b1;
        else if (t.height >= 3'd2)
            usable = t.slots[2'(t.height - 3'd1)] == t.slots[2'(t.height - 3'd2)];
        return usable;
    endfunction

    // Cyclic search starting after 'from', 'from' itself excluded
    function automatic searchT nextUsable(boardT b, tubeIndexT from);
        searchT res;
        int     t;
        res.found = 1'b0;
        res.idx   = from;
        for (int k = 1; k < numTubes; k++) begin
            t = int'(from) + k;
            if (t >= numTubes) t = t - numTubes;
            if (!res.found && isUsable(b[t])) begin
                res.found = 1'b1;
                res.idx   = tubeIndexT'(t);
            end
        end
        return res;
    endfunction

    ////////////////////////////////////////////////////////////
    // One scramble step
    ////////////////////////////////////////////////////////////
    always_comb begin
        dst      = '0;
        dstFound = 1'b0;
        for (int i = 0; i < numTubes; i++) begin
            if (!dstFound && i != int'(srcTube) && board[i].height < tubeDepth) begin
                dstFound = 1'b1;
                dst      = tubeIndexT'(i);
            end
        end
        moved  = dstFound ? moveBall(board, srcTube, dst) : board;
        newSrc = srcTube;
        halt   = !dstFound;
        refill = nextUsable(moved, srcTube);
        if (!isUsable(moved[srcTube])) begin   // Source spent, look elsewhere
            if (refill.found) newSrc = refill.idx;
            else halt = 1'b1;
        end
        skip = nextUsable(moved, newSrc);
        if (!halt && shuffleBit && skip.found) newSrc = skip.idx;
    end

    assign scrambleNext = moved;
    assign scrambleDone = stopped || pourCount == 7'(maxScramblePours);

    always_ff @(posedge single_pulse_clk) begin
        if (reset) begin
            srcTube   <= '0;
            pourCount <= '0;
            stopped   <= 1'b1;       // Idle until told to scramble
        end else if (scrambleInit) begin
            srcTube   <= '0;
            pourCount <= '0;
            stopped   <= 1'b0;
        end else if (!scrambleDone) begin
            srcTube   <= newSrc;
            pourCount <= pourCount + 7'd1;
            stopped   <= halt;
        end
    end

endmodule

// File: hdl/tubeBoard.sv
`timescale 1ns/1ps

module tubeBoard import potionPkg::*; (
    input  logic     single_pulse_clk,
    input  logic     reset,
    input  boardCmdT boardCmd,
    input  boardT    scrambleNext,   // From the scramble engine
    input  boardT    pouredBoard,    // From the pour unit
    output boardT    board
);

    // Solved layout: tube i holds four balls of colour i+1, last tube empty
    function automatic boardT startBoard();
        boardT b;
        for (int i = 0; i < numTubes; i++) begin
            if (i < numTubes - 1) begin
                for (int j = 0; j < tubeDepth; j++) begin
                    b[i].slots[j] = colourT'(i + 1);
                end
                b[i].height = heightT'(tubeDepth);
            end else begin
                for (int j = 0; j < tubeDepth; j++) begin
                    b[i].slots[j] = EMPTY;
                end
                b[i].height = 3'd0;
            end
        end
        return b;
    endfunction

    ////////////////////////////////////////////////////////////
    // Board register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge single_pulse_clk) begin
        if (reset) begin
            board <= startBoard();
        end else begin
            case (boardCmd)
                LOAD_START:    board <= startBoard();
                SCRAMBLE_STEP: board <= scrambleNext;   // One ball per cycle
                POUR_STEP:     board <= pouredBoard;    // Up to four balls
                HOLD:          board <= board;
            endcase
        end
    end

endmodule
